// File: conv_afu.f
hdl/conv_pkg.sv
hdl/read_request_engine.sv
hdl/buffer_store.sv
hdl/mac_sequencer.sv
hdl/writeback_unit.sv
hdl/conv_afu.sv
verification/conv_afu_tb.sv

// File: hdl/buffer_store.sv
// Image buffer and kernel banks
`timescale 1ns/1ps
`default_nettype none

module buffer_store #(
  parameter int MAX_MAPS = 512
) (
  input  wire                          clk,
  input  wire                          reset,
  input  wire                          rd_rsp_valid,
  input  wire conv_pkg::rd_rsp_t       rd_rsp,
  input  wire conv_pkg::job_cfg_t      job,
  input  wire [$clog2(MAX_MAPS)-1:0]   rd_index,
  input  wire                          rd_bank,
  input  wire                          bank_claim,
  input  wire                          bank_release,
  output logic [1:0]                   bank_full,
  output conv_pkg::cacheline_t         image_rd,
  output conv_pkg::cacheline_t         kernel_rd
);
  import conv_pkg::*;

  localparam int IDX_W = $clog2(MAX_MAPS);

  cacheline_t       image_mem  [MAX_MAPS];
  cacheline_t       kernel_mem [2][MAX_MAPS];
  logic [IDX_W-1:0] image_ptr;
  logic [IDX_W-1:0] kernel_ptr;
  logic [IDX_W-1:0] last_idx;
  logic             wr_bank;
  logic             claimed_bank;
  logic             image_we;
  logic             kernel_we;
  logic             kernel_last;

  // tag bit 0 picks the destination buffer
  assign image_we    = rd_rsp_valid && !rd_rsp.mdata[0];
  assign kernel_we   = rd_rsp_valid && rd_rsp.mdata[0];
  assign last_idx    = IDX_W'(job.num_maps - 1'b1);
  assign kernel_last = (kernel_ptr == last_idx);

  always_ff @(posedge clk) begin
    if (image_we) begin
      image_mem[image_ptr] <= rd_rsp.data;
    end
    if (kernel_we) begin
      kernel_mem[wr_bank][kernel_ptr] <= rd_rsp.data;
    end
  end

  // write pointers wrap after D cachelines
  always_ff @(posedge clk) begin
    if (reset) begin
      image_ptr    <= '0;
      kernel_ptr   <= '0;
      wr_bank      <= 1'b0;
      claimed_bank <= 1'b0;
    end else begin
      if (image_we) begin
        image_ptr <= (image_ptr == last_idx) ? '0 : image_ptr + 1'b1;
      end
      if (kernel_we) begin
        if (kernel_last) begin
          kernel_ptr <= '0;
          wr_bank    <= ~wr_bank;
        end else begin
          kernel_ptr <= kernel_ptr + 1'b1;
        end
      end
      // release always refers to the bank claimed last
      if (bank_claim) begin
        claimed_bank <= rd_bank;
      end
    end
  end

  for (genvar b = 0; b < 2; b++) begin : g_bank
    bank_state_t state;
    logic        write_here;

    assign write_here   = kernel_we && (wr_bank == 1'(b));
    assign bank_full[b] = (state == FULL);

    always_ff @(posedge clk) begin
      if (reset) begin
        state <= VACANT;
      end else begin
        case (state)
          VACANT: begin
            // a one-map kernel fills in a single write
            if (write_here) begin
              state <= kernel_last ? FULL : FILL;
            end
          end
          FILL: begin
            if (write_here && kernel_last) begin
              state <= FULL;
            end
          end
          FULL: begin
            if (bank_claim && (rd_bank == 1'(b))) begin
              state <= DRAIN;
            end
          end
          default: begin
            if (bank_release && (claimed_bank == 1'(b))) begin
              state <= VACANT;
            end
          end
        endcase
      end
    end
  end

  // registered read port, data one cycle after rd_index
  always_ff @(posedge clk) begin
    image_rd  <= image_mem[rd_index];
    kernel_rd <= kernel_mem[rd_bank][rd_index];
  end

endmodule

`default_nettype wire

// File: hdl/conv_afu.sv
// Convolution accelerator top level
`timescale 1ns/1ps
`default_nettype none

module conv_afu #(
  parameter int MAX_MAPS   = 512,
  parameter int FIFO_DEPTH = 8
) (
  input  wire                      clk,
  input  wire                      reset,
  input  wire                      start,
  input  wire conv_pkg::job_cfg_t  cfg,
  input  wire                      rd_req_almostfull,
  output wire                      rd_req_en,
  output wire conv_pkg::rd_req_t   rd_req,
  input  wire                      rd_rsp_valid,
  input  wire conv_pkg::rd_rsp_t   rd_rsp,
  input  wire                      wr_req_almostfull,
  output wire                      wr_req_en,
  output wire conv_pkg::wr_req_t   wr_req,
  output wire                      done
);
  import conv_pkg::*;

  localparam int IDX_W = $clog2(MAX_MAPS);

  wire job_cfg_t   job;
  wire [1:0]       bank_full;
  wire cacheline_t image_rd;
  wire cacheline_t kernel_rd;
  wire [IDX_W-1:0] rd_index;
  wire             rd_bank;
  wire             bank_claim;
  wire             bank_release;
  wire             result_valid;
  wire cacheline_t result;
  wire             fifo_space;

  read_request_engine #(
    .MAX_MAPS (MAX_MAPS)
  ) u_read_request_engine (
    .clk               (clk),
    .reset             (reset),
    .start             (start),
    .cfg               (cfg),
    .rd_req_almostfull (rd_req_almostfull),
    .bank_release      (bank_release),
    .job               (job),
    .rd_req_en         (rd_req_en),
    .rd_req            (rd_req)
  );

  buffer_store #(
    .MAX_MAPS (MAX_MAPS)
  ) u_buffer_store (
    .clk          (clk),
    .reset        (reset),
    .rd_rsp_valid (rd_rsp_valid),
    .rd_rsp       (rd_rsp),
    .job          (job),
    .rd_index     (rd_index),
    .rd_bank      (rd_bank),
    .bank_claim   (bank_claim),
    .bank_release (bank_release),
    .bank_full    (bank_full),
    .image_rd     (image_rd),
    .kernel_rd    (kernel_rd)
  );

  mac_sequencer #(
    .MAX_MAPS (MAX_MAPS)
  ) u_mac_sequencer (
    .clk          (clk),
    .reset        (reset),
    .job          (job),
    .bank_full    (bank_full),
    .fifo_space   (fifo_space),
    .image_rd     (image_rd),
    .kernel_rd    (kernel_rd),
    .rd_index     (rd_index),
    .rd_bank      (rd_bank),
    .bank_claim   (bank_claim),
    .bank_release (bank_release),
    .result_valid (result_valid),
    .result       (result)
  );

  writeback_unit #(
    .FIFO_DEPTH (FIFO_DEPTH)
  ) u_writeback_unit (
    .clk               (clk),
    .reset             (reset),
    .start             (start),
    .job               (job),
    .result_valid      (result_valid),
    .result            (result),
    .wr_req_almostfull (wr_req_almostfull),
    .fifo_space        (fifo_space),
    .wr_req_en         (wr_req_en),
    .wr_req            (wr_req),
    .done              (done)
  );

endmodule

`default_nettype wire

// File: hdl/conv_pkg.sv
// Convolution accelerator shared types
`default_nettype none

package conv_pkg;

  // complex lanes carried by one cacheline
  localparam int LANES = 8;

  typedef logic [57:0]  cl_addr_t;
  typedef logic [13:0]  mdata_t;
  typedef logic [511:0] cacheline_t;
  typedef logic [15:0]  count_t;

  // real part sits in the low half of each 64-bit lane
  typedef struct packed {
    logic [31:0] im;
    logic [31:0] re;
  } complex_t;

  typedef struct packed {
    cl_addr_t image_base;
    cl_addr_t kernel_base;
    cl_addr_t dest_base;
    count_t   num_maps;
    count_t   num_kernels;
  } job_cfg_t;

  // mdata bit 0 set for kernel reads
  typedef struct packed {
    cl_addr_t addr;
    mdata_t   mdata;
  } rd_req_t;

  typedef struct packed {
    mdata_t     mdata;
    cacheline_t data;
  } rd_rsp_t;

  typedef struct packed {
    cl_addr_t   addr;
    mdata_t     mdata;
    cacheline_t data;
  } wr_req_t;

  typedef enum logic [1:0] {VACANT, FILL, FULL, DRAIN} bank_state_t;

endpackage

`default_nettype wire

// File: hdl/mac_sequencer.sv
// Complex multiply-accumulate sequencer
`timescale 1ns/1ps
`default_nettype none

module mac_sequencer #(
  parameter int MAX_MAPS = 512
) (
  input  wire                          clk,
  input  wire                          reset,
  input  wire conv_pkg::job_cfg_t      job,
  input  wire [1:0]                    bank_full,
  input  wire                          fifo_space,
  input  wire conv_pkg::cacheline_t    image_rd,
  input  wire conv_pkg::cacheline_t    kernel_rd,
  output logic [$clog2(MAX_MAPS)-1:0]  rd_index,
  output logic                         rd_bank,
  output logic                         bank_claim,
  output logic                         bank_release,
  output logic                         result_valid,
  output wire conv_pkg::cacheline_t    result
);
  import conv_pkg::*;

  localparam int IDX_W = $clog2(MAX_MAPS);

  typedef enum logic {IDLE, RUN} exec_state_t;

  exec_state_t      state;
  logic [IDX_W-1:0] last_idx;
  logic             busy;
  logic             rd_v;
  logic             rd_first;
  logic             rd_last;
  logic             prod_v;
  logic             prod_first;
  logic             prod_last;

  assign last_idx = IDX_W'(job.num_maps - 1'b1);
  // one kernel in the pipeline at a time
  assign busy = rd_v || prod_v || result_valid;

  always_ff @(posedge clk) begin
    if (reset) begin
      state      <= IDLE;
      rd_index   <= '0;
      rd_bank    <= 1'b0;
      bank_claim <= 1'b0;
    end else begin
      bank_claim <= 1'b0;
      case (state)
        IDLE: begin
          if (bank_full[rd_bank] && fifo_space && !busy) begin
            state      <= RUN;
            bank_claim <= 1'b1;
            rd_index   <= '0;
          end
        end
        default: begin
          if (rd_index == last_idx) begin
            // next kernel comes from the other bank
            state   <= IDLE;
            rd_bank <= ~rd_bank;
          end else begin
            rd_index <= rd_index + 1'b1;
          end
        end
      endcase
    end
  end

  // read, product, accumulate
  always_ff @(posedge clk) begin
    if (reset) begin
      rd_v         <= 1'b0;
      prod_v       <= 1'b0;
      result_valid <= 1'b0;
      bank_release <= 1'b0;
    end else begin
      rd_v         <= (state == RUN);
      prod_v       <= rd_v;
      result_valid <= prod_v && prod_last;
      bank_release <= prod_v && prod_last;
    end
  end

  always_ff @(posedge clk) begin
    rd_first   <= (rd_index == '0);
    rd_last    <= (rd_index == last_idx);
    prod_first <= rd_first;
    prod_last  <= rd_last;
  end

  for (genvar n = 0; n < LANES; n++) begin : g_lane
    complex_t img;
    complex_t krn;
    complex_t prod;
    complex_t acc;

    assign img = image_rd[64*n +: 64];
    assign krn = kernel_rd[64*n +: 64];

    // products wrap to 32 bits per part
    always_ff @(posedge clk) begin
      if (rd_v) begin
        prod.re <= img.re * krn.re - img.im * krn.im;
        prod.im <= img.re * krn.im + img.im * krn.re;
      end
    end

    // first map restarts the sum
    always_ff @(posedge clk) begin
      if (prod_v) begin
        if (prod_first) begin
          acc <= prod;
        end else begin
          acc.re <= acc.re + prod.re;
          acc.im <= acc.im + prod.im;
        end
      end
    end

    assign result[64*n +: 64] = acc;
  end

endmodule

`default_nettype wire

// File: hdl/read_request_engine.sv
// Read request sequencer
`timescale 1ns/1ps
`default_nettype none

module read_request_engine #(
  parameter int MAX_MAPS = 512
) (
  input  wire                      clk,
  input  wire                      reset,
  input  wire                      start,
  input  wire conv_pkg::job_cfg_t  cfg,
  input  wire                      rd_req_almostfull,
  input  wire                      bank_release,
  output conv_pkg::job_cfg_t       job,
  output logic                     rd_req_en,
  output conv_pkg::rd_req_t        rd_req
);
  import conv_pkg::*;

  localparam int CNT_W = $clog2(MAX_MAPS + 1);

  typedef enum logic [1:0] {IDLE, IMAGE, KERNEL_WAIT, KERNEL} rd_state_t;

  rd_state_t        state;
  cl_addr_t         addr;
  logic [CNT_W-1:0] map_cnt;
  count_t           kernel_cnt;
  logic [1:0]       credits;
  logic             take_credit;
  logic             issue;
  logic             last_map;

  assign last_map    = (map_cnt == CNT_W'(job.num_maps - 1'b1));
  assign issue       = ((state == IMAGE) || (state == KERNEL)) && !rd_req_almostfull;
  assign take_credit = (state == KERNEL_WAIT) && (credits != 2'd0);

  // one credit per kernel bank
  always_ff @(posedge clk) begin
    if (reset) begin
      credits <= 2'd2;
    end else begin
      credits <= credits - {1'b0, take_credit} + {1'b0, bank_release};
    end
  end

  // descriptor held for the whole job
  always_ff @(posedge clk) begin
    if (reset) begin
      job <= '0;
    end else if ((state == IDLE) && start) begin
      job <= cfg;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      state      <= IDLE;
      rd_req_en  <= 1'b0;
      map_cnt    <= '0;
      kernel_cnt <= '0;
    end else begin
      rd_req_en <= issue;
      case (state)
        IDLE: begin
          map_cnt    <= '0;
          kernel_cnt <= '0;
          if (start) begin
            state <= IMAGE;
          end
        end
        IMAGE: begin
          if (issue) begin
            map_cnt <= last_map ? '0 : map_cnt + 1'b1;
            if (last_map) begin
              state <= KERNEL_WAIT;
            end
          end
        end
        KERNEL_WAIT: begin
          if (take_credit) begin
            state <= KERNEL;
          end
        end
        default: begin
          if (issue) begin
            map_cnt <= last_map ? '0 : map_cnt + 1'b1;
            if (last_map) begin
              kernel_cnt <= kernel_cnt + 1'b1;
              // last kernel load ends the read side of the job
              state <= (kernel_cnt == job.num_kernels - 1'b1) ? IDLE : KERNEL_WAIT;
            end
          end
        end
      endcase
    end
  end

  // kernel addresses run on from kernel_base without gaps
  always_ff @(posedge clk) begin
    if (state == IDLE) begin
      addr <= cfg.image_base;
    end else if (issue) begin
      rd_req.addr  <= addr;
      rd_req.mdata <= (state == KERNEL) ? mdata_t'(1) : mdata_t'(0);
      addr         <= ((state == IMAGE) && last_map) ? job.kernel_base : addr + 1'b1;
    end
  end

endmodule

`default_nettype wire

// File: hdl/writeback_unit.sv
// Output FIFO and write requests
`timescale 1ns/1ps
`default_nettype none

module writeback_unit #(
  parameter int FIFO_DEPTH = 8
) (
  input  wire                        clk,
  input  wire                        reset,
  input  wire                        start,
  input  wire conv_pkg::job_cfg_t    job,
  input  wire                        result_valid,
  input  wire conv_pkg::cacheline_t  result,
  input  wire                        wr_req_almostfull,
  output logic                       fifo_space,
  output logic                       wr_req_en,
  output conv_pkg::wr_req_t          wr_req,
  output logic                       done
);
  import conv_pkg::*;

  localparam int PTR_W = $clog2(FIFO_DEPTH);

  cacheline_t       fifo_mem [FIFO_DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [PTR_W:0]   fill;
  logic             pop;
  count_t           wr_cnt;

  assign pop        = (fill != '0) && !wr_req_almostfull;
  assign fifo_space = (fill < (PTR_W + 1)'(FIFO_DEPTH));

  always_ff @(posedge clk) begin
    if (result_valid) begin
      fifo_mem[wr_ptr] <= result;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      fill   <= '0;
    end else begin
      if (result_valid) begin
        wr_ptr <= (wr_ptr == PTR_W'(FIFO_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= (rd_ptr == PTR_W'(FIFO_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      end
      fill <= fill + (PTR_W + 1)'(result_valid) - (PTR_W + 1)'(pop);
    end
  end

  // output j goes to dest_base + j
  always_ff @(posedge clk) begin
    if (pop) begin
      wr_req.addr  <= job.dest_base + cl_addr_t'(wr_cnt);
      wr_req.mdata <= '0;
      wr_req.data  <= fifo_mem[rd_ptr];
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      wr_req_en <= 1'b0;
      wr_cnt    <= '0;
      done      <= 1'b0;
    end else begin
      wr_req_en <= pop;
      if (start) begin
        wr_cnt <= '0;
        done   <= 1'b0;
      end else begin
        if (pop) begin
          wr_cnt <= wr_cnt + 1'b1;
        end
        // wr_cnt already counts the request on the bus
        if (wr_req_en && (wr_cnt == job.num_kernels)) begin
          done <= 1'b1;
        end
      end
    end
  end

endmodule

`default_nettype wire

// File: verification/conv_afu_tb.sv
// Convolution accelerator testbench
`timescale 1ns/1ps
`default_nettype none

module conv_afu_tb;
  import conv_pkg::*;

  // reads per test are D*(K+1)
  localparam int TOTAL_READS     = 1*2 + 4*4 + 5*4 + 3*5 + 6*6 + 2*3 + 3*3;
  localparam int WATCHDOG_CYCLES = 40 * TOTAL_READS + 2000;

  logic      clk;
  logic      reset;
  logic      start;
  job_cfg_t  cfg;
  logic      rd_req_almostfull;
  logic      rd_rsp_valid;
  rd_rsp_t   rd_rsp;
  logic      wr_req_almostfull;
  wire       rd_req_en;
  wire       wr_req_en;
  wire       done;
  wire rd_req_t rd_req;
  wire wr_req_t wr_req;

  cacheline_t  mem [cl_addr_t];
  rd_req_t     rd_q[$];
  rd_req_t     pend_q[$];
  int          pend_due[$];
  wr_req_t     wr_q[$];
  int          cycle_cnt;
  logic [15:0] data_lfsr;
  logic [15:0] delay_lfsr;
  logic [15:0] af_lfsr;
  logic [31:0] delay_bits;
  logic [31:0] af_bits;
  logic        rd_af_random;
  logic        rd_af_seen;
  logic        wr_af_seen;

  conv_afu #(
    .MAX_MAPS   (64),
    .FIFO_DEPTH (8)
  ) u_dut (
    .clk               (clk),
    .reset             (reset),
    .start             (start),
    .cfg               (cfg),
    .rd_req_almostfull (rd_req_almostfull),
    .rd_req_en         (rd_req_en),
    .rd_req            (rd_req),
    .rd_rsp_valid      (rd_rsp_valid),
    .rd_rsp            (rd_rsp),
    .wr_req_almostfull (wr_req_almostfull),
    .wr_req_en         (wr_req_en),
    .wr_req            (wr_req),
    .done              (done)
  );

  always #4 clk = ~clk;

  // x^16 + x^14 + x^13 + x^11 + 1
  function automatic logic [15:0] lfsr_step(input logic [15:0] s);
    return {s[0] ^ s[2] ^ s[3] ^ s[5], s[15:1]};
  endfunction

  task automatic draw(inout logic [15:0] state, input int n, output logic [31:0] bits);
    bits = '0;
    for (int i = 0; i < n; i++) begin
      bits  = {bits[30:0], state[0]};
      state = lfsr_step(state);
    end
  endtask

  task automatic check_value(input logic [511:0] got, input logic [511:0] exp,
                             input string what);
    if (got !== exp) begin
      $display("Error at %0t ns: %s: got %0h, expected %0h", $time, what, got, exp);
      $display(">>> FAIL");
      $fatal(1, "mismatch in %s", what);
    end
  endtask

  function automatic cacheline_t read_mem(input cl_addr_t a);
    return mem.exists(a) ? mem[a] : '0;
  endfunction

  function automatic job_cfg_t make_cfg(input cl_addr_t ib, input cl_addr_t kb,
                                        input cl_addr_t db, input int d, input int k);
    job_cfg_t c;
    c.image_base  = ib;
    c.kernel_base = kb;
    c.dest_base   = db;
    c.num_maps    = count_t'(d);
    c.num_kernels = count_t'(k);
    return c;
  endfunction

  // out_j per lane with 32-bit wrap per part
  function automatic cacheline_t expected_out(input job_cfg_t c, input int j);
    cacheline_t line;
    cacheline_t img_line;
    cacheline_t krn_line;
    complex_t   a;
    complex_t   b;
    complex_t   acc;
    line = '0;
    for (int n = 0; n < LANES; n++) begin
      acc = '0;
      for (int d = 0; d < c.num_maps; d++) begin
        img_line = read_mem(c.image_base + cl_addr_t'(d));
        krn_line = read_mem(c.kernel_base + cl_addr_t'(j * c.num_maps + d));
        a = img_line[64*n +: 64];
        b = krn_line[64*n +: 64];
        acc.re = acc.re + a.re * b.re - a.im * b.im;
        acc.im = acc.im + a.re * b.im + a.im * b.re;
      end
      line[64*n +: 64] = acc;
    end
    return line;
  endfunction

  task automatic fill_lines(input cl_addr_t base, input int count);
    cacheline_t  line;
    logic [31:0] bits;
    for (int i = 0; i < count; i++) begin
      for (int k = 0; k < 16; k++) begin
        draw(data_lfsr, 32, bits);
        line[32*k +: 32] = bits;
      end
      mem[base + cl_addr_t'(i)] = line;
    end
  endtask

  // memory model answers in order once due
  always @(posedge clk) begin
    cycle_cnt = cycle_cnt + 1;
    rd_rsp_valid <= 1'b0;
    if ((pend_q.size() != 0) && (pend_due[0] <= cycle_cnt)) begin
      rd_rsp_valid <= 1'b1;
      rd_rsp.mdata <= pend_q[0].mdata;
      rd_rsp.data  <= read_mem(pend_q[0].addr);
      void'(pend_q.pop_front());
      void'(pend_due.pop_front());
    end
  end

  always @(posedge clk) begin
    if (rd_af_random) begin
      draw(af_lfsr, 1, af_bits);
      rd_req_almostfull <= af_bits[0];
    end else begin
      rd_req_almostfull <= 1'b0;
    end
  end

  // request monitor against almost-full of the previous cycle
  always @(negedge clk) begin
    if (!reset) begin
      check_value(rd_req_en & rd_af_seen, 1'b0, "read request after almost-full");
      check_value(wr_req_en & wr_af_seen, 1'b0, "write request after almost-full");
      if (rd_req_en) begin
        rd_q.push_back(rd_req);
        pend_q.push_back(rd_req);
        draw(delay_lfsr, 2, delay_bits);
        pend_due.push_back(cycle_cnt + int'(delay_bits) + 1);
      end
      if (wr_req_en) begin
        wr_q.push_back(wr_req);
      end
    end
    rd_af_seen = rd_req_almostfull;
    wr_af_seen = wr_req_almostfull;
  end

  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge clk);
    $display(">>> FAIL");
    $fatal(1, "watchdog expired before the tests finished");
  end

  task automatic apply_reset;
    @(posedge clk);
    reset <= 1'b1;
    repeat (5) @(posedge clk);
    reset <= 1'b0;
    @(negedge clk);
    check_value(done, 1'b0, "done after reset");
  endtask

  task automatic start_job(input job_cfg_t c);
    rd_q.delete();
    wr_q.delete();
    @(posedge clk);
    cfg   <= c;
    start <= 1'b1;
    @(posedge clk);
    start <= 1'b0;
    @(negedge clk);
    check_value(done, 1'b0, "done after start");
  endtask

  task automatic wait_done;
    @(negedge clk);
    while (!done) begin
      @(negedge clk);
    end
  endtask

  task automatic check_job(input job_cfg_t c);
    int n_img;
    n_img = c.num_maps;
    check_value(rd_q.size(), c.num_maps * (c.num_kernels + 1), "read request count");
    for (int i = 0; i < rd_q.size(); i++) begin
      if (i < n_img) begin
        check_value(rd_q[i].addr, c.image_base + cl_addr_t'(i), "image read address");
        check_value(rd_q[i].mdata[0], 1'b0, "image read tag");
      end else begin
        check_value(rd_q[i].addr, c.kernel_base + cl_addr_t'(i - n_img),
                    "kernel read address");
        check_value(rd_q[i].mdata[0], 1'b1, "kernel read tag");
      end
    end
    check_value(wr_q.size(), c.num_kernels, "write request count");
    for (int j = 0; j < wr_q.size(); j++) begin
      check_value(wr_q[j].addr, c.dest_base + cl_addr_t'(j), $sformatf("write %0d address", j));
      check_value(wr_q[j].mdata, '0, $sformatf("write %0d mdata", j));
      check_value(wr_q[j].data, expected_out(c, j), $sformatf("write %0d data", j));
    end
  endtask

  task automatic run_job(input job_cfg_t c);
    fill_lines(c.image_base, c.num_maps);
    fill_lines(c.kernel_base, c.num_maps * c.num_kernels);
    start_job(c);
    wait_done();
    check_job(c);
  endtask

  task automatic single_kernel_test;
    run_job(make_cfg(58'h100, 58'h200, 58'h300, 1, 1));
  endtask

  task automatic multi_kernel_test;
    run_job(make_cfg(58'h1000, 58'h2000, 58'h3000, 4, 3));
  endtask

  task automatic read_backpressure_test;
    rd_af_random = 1'b1;
    run_job(make_cfg(58'h4000, 58'h5000, 58'h6000, 5, 3));
    rd_af_random = 1'b0;
  endtask

  // four results wait in the output FIFO
  task automatic write_backpressure_test;
    job_cfg_t c;
    c = make_cfg(58'h7000, 58'h8000, 58'h9000, 3, 4);
    fill_lines(c.image_base, 3);
    fill_lines(c.kernel_base, 12);
    @(posedge clk);
    wr_req_almostfull <= 1'b1;
    start_job(c);
    repeat (48) @(posedge clk);
    check_value(wr_q.size(), 0, "writes while almost-full held");
    wr_req_almostfull <= 1'b0;
    wait_done();
    check_job(c);
  endtask

  task automatic ping_pong_test;
    run_job(make_cfg(58'ha000, 58'hb000, 58'hc000, 6, 5));
  endtask

  task automatic done_behavior_test;
    apply_reset();
    run_job(make_cfg(58'hd000, 58'he000, 58'hf000, 2, 2));
    repeat (3) @(negedge clk);
    check_value(done, 1'b1, "done held after job");
    // back-to-back job on new bases
    run_job(make_cfg(58'h11000, 58'h12000, 58'h13000, 3, 2));
  endtask

  initial begin
    clk               = 1'b0;
    reset             = 1'b1;
    start             = 1'b0;
    cfg               = '0;
    rd_req_almostfull = 1'b0;
    rd_rsp_valid      = 1'b0;
    rd_rsp            = '0;
    wr_req_almostfull = 1'b0;
    cycle_cnt         = 0;
    data_lfsr         = 16'd8618;
    delay_lfsr        = 16'd8618;
    af_lfsr           = 16'd8618;
    rd_af_random      = 1'b0;
    rd_af_seen        = 1'b0;
    wr_af_seen        = 1'b0;
    apply_reset();
    single_kernel_test();
    multi_kernel_test();
    read_backpressure_test();
    write_backpressure_test();
    ping_pong_test();
    done_behavior_test();
    $display(">>> PASS");
    $finish;
  end

endmodule

`default_nettype wire
